// ==== common/gnn_pkg.sv ====
`default_nettype none

package gnn_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int NUM_LANES   = 4;
  localparam int LANE_W      = 12;
  localparam int LANE_IDX_W  = $clog2(NUM_LANES);
  localparam int H_ADDR_W    = 8;
  localparam int H_DEPTH     = 2 ** H_ADDR_W;
  localparam int H_WORD_W    = 19;
  localparam int HOST_DATA_W = NUM_LANES * LANE_W;
  localparam int WGT_COLS    = 64;
  localparam int COL_W       = 6;
  localparam int ENT_CNT_W   = 6;
  localparam int RSVD_W      = 12;
  localparam int MAX_NODES   = 16;
  localparam int ROW_W       = $clog2(MAX_NODES);
  localparam int NODE_W      = ROW_W + 1;
  localparam int FEAT_ADDR_W = 16;
  localparam int FEAT_DATA_W = 32;
  localparam int DBG_W       = 32;
  localparam int DBG_CNT_W   = 16;

  // --------------------------------------------------
  // encodings and debug constants
  // --------------------------------------------------
  localparam logic KIND_HDR  = 1'b1;  // bit 18 of an h_data word
  localparam logic KIND_ENT  = 1'b0;
  localparam logic SEL_HDATA = 1'b0;  // host write goes to the adjacency memory
  localparam logic SEL_WGT   = 1'b1;  // host write goes to the weight table

  localparam logic [FEAT_ADDR_W-1:0] FEAT_WIN_BASE = 16'd40;
  localparam logic [ROW_W-1:0]       TRIG_ROW_A    = 4'd3;
  localparam logic [ROW_W-1:0]       TRIG_ROW_B    = 4'd9;
  localparam int                     CAP_LANE      = 2;
  localparam logic [DBG_W-1:0]       BUILD_ID      = 32'h474e_0a17;

  // --------------------------------------------------
  // h_data word read as a row header or as an entry
  // --------------------------------------------------
  typedef struct packed {
    logic                 kind;
    logic [ENT_CNT_W-1:0] count;  // entries that follow this header
    logic [RSVD_W-1:0]    rsvd;
  } header_t;

  typedef struct packed {
    logic                     kind;
    logic [COL_W-1:0]         col;
    logic signed [LANE_W-1:0] val;
  } entry_t;

  typedef union packed {
    header_t hdr;
    entry_t  ent;
  } h_data_word_u;

  typedef struct packed {
    logic                   we;
    logic                   sel;
    logic [H_ADDR_W-1:0]    addr;
    logic [HOST_DATA_W-1:0] data;
  } host_wr_t;

  typedef struct packed {
    logic [NUM_LANES-1:0][LANE_W-1:0] lane;
  } sppe_t;

  typedef struct packed {
    logic                   ena;
    logic [FEAT_ADDR_W-1:0] addr;
    logic [FEAT_DATA_W-1:0] data;
  } feat_wr_t;

  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_evt_t;

endpackage

`default_nettype wire

// ==== hw/layer_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module layer_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  logic [gnn_pkg::NODE_W-1:0] num_nodes_i,
  input  logic                       aggr_rdy_i,
  output logic                       row_go_o,
  output logic [gnn_pkg::ROW_W-1:0]  row_idx_o,
  output logic                       done_o
);

  import gnn_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_GO,
    S_WAIT
  } state_e;

  state_e              state_q;
  logic [NODE_W-1:0]   num_q;
  logic [ROW_W-1:0]    row_q;
  logic                done_q;
  logic                last_row;

  assign last_row = (NODE_W'(row_q) + NODE_W'(1)) == num_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      num_q   <= '0;
      row_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            num_q <= num_nodes_i;  // node count is frozen for the whole run
            row_q <= '0;
            if (num_nodes_i == '0) begin
              done_q <= 1'b1;  // empty layer finishes at once
            end else begin
              state_q <= S_GO;
            end
          end
        end
        S_GO: begin
          state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (aggr_rdy_i) begin
            if (last_row) begin
              state_q <= S_IDLE;
              done_q  <= 1'b1;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= S_GO;  // next row goes out one cycle after aggr_rdy
            end
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  assign row_go_o  = (state_q == S_GO);
  assign row_idx_o = row_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

// ==== spmm/h_data_bram.sv ====
`timescale 1ns/1ns
`default_nettype none

module h_data_bram (
  input  logic                         clk,
  input  gnn_pkg::host_wr_t            host_wr_i,
  input  logic [gnn_pkg::H_ADDR_W-1:0] rd_addr_i,
  output gnn_pkg::h_data_word_u        rd_data_o
);

  import gnn_pkg::*;

  logic [H_WORD_W-1:0] mem [H_DEPTH];
  logic                wr_en;

  assign wr_en = host_wr_i.we && (host_wr_i.sel == SEL_HDATA);

  // --------------------------------------------------
  // single port with host write and registered read
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[host_wr_i.addr] <= host_wr_i.data[H_WORD_W-1:0];  // upper data bits are ignored
    end
    rd_data_o <= h_data_word_u'(mem[rd_addr_i]);
  end

endmodule

`default_nettype wire

// ==== spmm/spmm_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module spmm_engine (
  input  logic                         clk,
  input  logic                         rst_n,
  input  gnn_pkg::host_wr_t            host_wr_i,
  input  logic                         row_go_i,
  output logic [gnn_pkg::H_ADDR_W-1:0] h_addr_o,
  input  gnn_pkg::h_data_word_u        h_data_i,
  output gnn_pkg::sppe_t               sppe_o,
  output logic                         spmm_rdy_o,
  output logic                         spmm_vld_o
);

  import gnn_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_CNT,
    S_ENT,
    S_VLD
  } state_e;

  state_e                   state_q;
  logic [H_ADDR_W-1:0]      ptr_q;
  logic [ENT_CNT_W-1:0]     remain_q;
  sppe_t                    acc_q;
  sppe_t                    acc_nxt;
  sppe_t                    wgt_row;
  logic [HOST_DATA_W-1:0]   wgt_mem [WGT_COLS];
  logic signed [2*LANE_W-1:0] prod [NUM_LANES];
  logic                     accept;

  assign accept = row_go_i && (state_q == S_IDLE);

  always_ff @(posedge clk) begin
    if (host_wr_i.we && (host_wr_i.sel == SEL_WGT)) begin
      wgt_mem[host_wr_i.addr[COL_W-1:0]] <= host_wr_i.data;
    end
  end

  // --------------------------------------------------
  // per-lane multiply-accumulate with 12-bit wrap
  // --------------------------------------------------
  assign wgt_row = sppe_t'(wgt_mem[h_data_i.ent.col]);

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      prod[k]         = $signed(h_data_i.ent.val) * $signed(wgt_row.lane[k]);
      acc_nxt.lane[k] = acc_q.lane[k] + prod[k][LANE_W-1:0];
    end
  end

  // the read pointer only runs forward since rows sit back to back in h_data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= S_IDLE;
      ptr_q    <= '0;
      remain_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (row_go_i) begin
            state_q <= S_HDR;
            ptr_q   <= ptr_q + 1'b1;  // header is being read on this edge
          end
        end
        S_HDR: begin
          remain_q <= h_data_i.hdr.count;
          state_q  <= S_CNT;
        end
        S_CNT: begin
          if (remain_q == '0) begin
            state_q <= S_VLD;
          end else begin
            ptr_q   <= ptr_q + 1'b1;
            state_q <= S_ENT;
          end
        end
        S_ENT: begin
          remain_q <= remain_q - 1'b1;
          if (remain_q == ENT_CNT_W'(1)) begin
            state_q <= S_VLD;  // pointer now sits on the next header
          end else begin
            ptr_q <= ptr_q + 1'b1;
          end
        end
        S_VLD: begin
          state_q <= S_IDLE;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q <= '0;
    end else if (state_q == S_ENT) begin
      acc_q <= acc_nxt;
    end
  end

  assign h_addr_o   = ptr_q;
  assign sppe_o     = acc_q;  // held until the next row is accepted
  assign spmm_rdy_o = accept;
  assign spmm_vld_o = (state_q == S_VLD);

  a_row_go_idle : assert property (@(posedge clk) disable iff (!rst_n)
    row_go_i |-> state_q == S_IDLE);

  // memory layout must line up with the pointer walk
  a_hdr_kind : assert property (@(posedge clk) disable iff (!rst_n)
    state_q == S_HDR |-> h_data_i.hdr.kind == KIND_HDR);

  a_ent_kind : assert property (@(posedge clk) disable iff (!rst_n)
    state_q == S_ENT |-> h_data_i.ent.kind == KIND_ENT);

endmodule

`default_nettype wire

// ==== hw/aggr_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module aggr_writer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      spmm_vld_i,
  input  gnn_pkg::sppe_t            sppe_i,
  input  logic [gnn_pkg::ROW_W-1:0] row_idx_i,
  output gnn_pkg::feat_wr_t         feat_wr_o,
  output logic                      aggr_vld_o,
  output logic                      aggr_rdy_o
);

  import gnn_pkg::*;

  logic                  busy_q;
  logic [LANE_IDX_W-1:0] lane_q;
  logic [ROW_W-1:0]      row_q;
  sppe_t                 sppe_q;
  logic [LANE_W-1:0]     cur_lane;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      lane_q <= '0;
    end else if (spmm_vld_i) begin
      busy_q <= 1'b1;
      lane_q <= '0;
    end else if (busy_q) begin
      lane_q <= lane_q + 1'b1;
      if (lane_q == LANE_IDX_W'(NUM_LANES - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (spmm_vld_i) begin
      sppe_q <= sppe_i;
      row_q  <= row_idx_i;
    end
  end

  assign cur_lane = sppe_q.lane[lane_q];

  always_comb begin
    feat_wr_o.ena  = busy_q;
    feat_wr_o.addr = FEAT_ADDR_W'({row_q, lane_q});  // row * 4 + lane
    feat_wr_o.data = {{(FEAT_DATA_W - LANE_W){cur_lane[LANE_W-1]}}, cur_lane};
  end

  assign aggr_vld_o = busy_q;
  assign aggr_rdy_o = busy_q && (lane_q == LANE_IDX_W'(NUM_LANES - 1));  // with the last lane

  a_no_vld_busy : assert property (@(posedge clk) disable iff (!rst_n)
    spmm_vld_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== debug/debug_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_monitor (
  input  logic                      clk,
  input  logic                      rst_n,
  input  gnn_pkg::stage_evt_t       evt_i,
  input  gnn_pkg::sppe_t            sppe_i,
  input  logic [gnn_pkg::ROW_W-1:0] row_idx_i,
  input  gnn_pkg::feat_wr_t         feat_wr_i,
  output logic [gnn_pkg::DBG_W-1:0] debug_1_o,
  output logic [gnn_pkg::DBG_W-1:0] debug_2_o,
  output logic [gnn_pkg::DBG_W-1:0] debug_3_o
);

  import gnn_pkg::*;

  stage_evt_t           flags_q;
  logic                 win_q;
  logic [DBG_CNT_W-1:0] row_cnt_q;
  logic [LANE_W-1:0]    cap_a_q;
  logic [LANE_W-1:0]    cap_b_q;
  logic                 hit_a;
  logic                 hit_b;
  logic                 in_win;

  assign hit_a  = evt_i.spmm_vld && (row_idx_i == TRIG_ROW_A);
  assign hit_b  = evt_i.spmm_vld && (row_idx_i == TRIG_ROW_B);
  assign in_win = feat_wr_i.ena && (feat_wr_i.addr >= FEAT_WIN_BASE);

  // --------------------------------------------------
  // sticky stage flags and window flag
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      win_q   <= 1'b0;
    end else begin
      flags_q <= stage_evt_t'(flags_q | evt_i);  // only reset clears them
      if (in_win) begin
        win_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // row counter and lane captures
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_cnt_q <= '0;
      cap_a_q   <= '0;
      cap_b_q   <= '0;
    end else begin
      if (evt_i.spmm_vld) begin
        row_cnt_q <= row_cnt_q + 1'b1;  // one per finished sparse row
      end
      if (hit_a) begin
        cap_a_q <= sppe_i.lane[CAP_LANE];
      end
      if (hit_b) begin
        cap_b_q <= sppe_i.lane[CAP_LANE];
      end
    end
  end

  // debug_2 layout is count in [31:16], window in [4], flags in [3:0]
  assign debug_1_o = BUILD_ID;
  assign debug_2_o = {row_cnt_q, 11'b0, win_q, flags_q};
  assign debug_3_o = {16'(cap_b_q), 16'(cap_a_q)};

endmodule

`default_nettype wire

// ==== hw/gnn_layer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module gnn_layer_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  logic [gnn_pkg::NODE_W-1:0] num_nodes_i,
  input  gnn_pkg::host_wr_t          host_wr_i,
  output logic                       done_o,
  output gnn_pkg::feat_wr_t          feat_wr_o,
  output logic [gnn_pkg::DBG_W-1:0]  debug_1_o,
  output logic [gnn_pkg::DBG_W-1:0]  debug_2_o,
  output logic [gnn_pkg::DBG_W-1:0]  debug_3_o
);

  import gnn_pkg::*;

  logic                row_go;
  logic [ROW_W-1:0]    row_idx;
  logic [H_ADDR_W-1:0] h_addr;
  h_data_word_u        h_rd_data;
  sppe_t               sppe;
  logic                spmm_rdy;
  logic                spmm_vld;
  logic                aggr_vld;
  logic                aggr_rdy;
  feat_wr_t            feat_wr;
  stage_evt_t          evt;

  layer_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_nodes_i (num_nodes_i),
    .aggr_rdy_i  (aggr_rdy),
    .row_go_o    (row_go),
    .row_idx_o   (row_idx),
    .done_o      (done_o)
  );

  h_data_bram u_hbram (
    .clk       (clk),
    .host_wr_i (host_wr_i),
    .rd_addr_i (h_addr),
    .rd_data_o (h_rd_data)
  );

  spmm_engine u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_wr_i  (host_wr_i),
    .row_go_i   (row_go),
    .h_addr_o   (h_addr),
    .h_data_i   (h_rd_data),
    .sppe_o     (sppe),
    .spmm_rdy_o (spmm_rdy),
    .spmm_vld_o (spmm_vld)
  );

  aggr_writer u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .spmm_vld_i (spmm_vld),
    .sppe_i     (sppe),
    .row_idx_i  (row_idx),
    .feat_wr_o  (feat_wr),
    .aggr_vld_o (aggr_vld),
    .aggr_rdy_o (aggr_rdy)
  );

  assign evt.spmm_vld = spmm_vld;
  assign evt.spmm_rdy = spmm_rdy;
  assign evt.aggr_vld = aggr_vld;
  assign evt.aggr_rdy = aggr_rdy;
  assign feat_wr_o    = feat_wr;

  debug_monitor u_dbg (
    .clk       (clk),
    .rst_n     (rst_n),
    .evt_i     (evt),
    .sppe_i    (sppe),
    .row_idx_i (row_idx),
    .feat_wr_i (feat_wr),
    .debug_1_o (debug_1_o),
    .debug_2_o (debug_2_o),
    .debug_3_o (debug_3_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_gnn_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_gnn_layer;

  import gnn_pkg::*;

  localparam int MAX_ENT     = 8;
  localparam int ROW_BOUND   = 3 + MAX_ENT + NUM_LANES + 4;  // sparse walk plus writes and turnaround
  localparam int RUN_ROWS    = 1 + 12 + 10 + 11;
  localparam int LOAD_BOUND  = WGT_COLS + 4 * MAX_NODES * (MAX_ENT + 1);
  localparam int RESET_BOUND = 4 * 20;
  localparam int TIMEOUT_CYCLES = RUN_ROWS * (ROW_BOUND + 8) + LOAD_BOUND + RESET_BOUND + 500;

  logic              clk;
  logic              rst_n;
  logic              start_i;
  logic [NODE_W-1:0] num_nodes_i;
  host_wr_t          host_wr;
  logic              done_o;
  feat_wr_t          feat_wr;
  logic [DBG_W-1:0]  debug_1;
  logic [DBG_W-1:0]  debug_2;
  logic [DBG_W-1:0]  debug_3;

  // reference model state
  logic [LANE_W-1:0] wgt_m [WGT_COLS][NUM_LANES];
  int                row_cnt [MAX_NODES];
  logic [COL_W-1:0]  row_col [MAX_NODES][MAX_ENT];
  logic [LANE_W-1:0] row_val [MAX_NODES][MAX_ENT];

  logic [FEAT_ADDR_W-1:0] wr_addr_q [$];
  logic [FEAT_DATA_W-1:0] wr_data_q [$];
  int                     wr_cyc_q [$];
  int                     done_cnt = 0;
  int                     cycle_cnt = 0;
  int                     n_checks = 0;
  int                     n_errors = 0;
  logic [31:0]            lcg_state;

  gnn_layer_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_nodes_i (num_nodes_i),
    .host_wr_i   (host_wr),
    .done_o      (done_o),
    .feat_wr_o   (feat_wr),
    .debug_1_o   (debug_1),
    .debug_2_o   (debug_2),
    .debug_3_o   (debug_3)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // collects feature writes and done pulses on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (feat_wr.ena) begin
        wr_addr_q.push_back(feat_wr.addr);
        wr_data_q.push_back(feat_wr.data);
        wr_cyc_q.push_back(cycle_cnt);
      end
      if (done_o) begin
        done_cnt++;
      end
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0, lcg_state[31:16]};
  endfunction

  function automatic int sext12(input logic [LANE_W-1:0] x);
    return {{20{x[LANE_W-1]}}, x};
  endfunction

  // signed products summed per lane and wrapped to 12 bits
  function automatic logic [LANE_W-1:0] lane_sum(input int r, input int k);
    logic [LANE_W-1:0] acc;
    int                prod;
    acc = '0;
    for (int e = 0; e < row_cnt[r]; e++) begin
      prod = sext12(row_val[r][e]) * sext12(wgt_m[row_col[r][e]][k]);
      acc  = acc + prod[LANE_W-1:0];
    end
    return acc;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    assert (cond) else begin
      n_errors++;
      $display("%s", msg);
    end
  endtask

  task automatic do_reset();
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic host_write(input logic sel, input int addr, input logic [HOST_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    host_wr.we   = 1'b1;
    host_wr.sel  = sel;
    host_wr.addr = addr[H_ADDR_W-1:0];
    host_wr.data = data;
  endtask

  task automatic host_release();
    @(posedge clk);
    #1;
    host_wr = '0;
  endtask

  task automatic write_weight_row(input int col, input int w0, input int w1, input int w2,
                                  input int w3);
    wgt_m[col][0] = w0[LANE_W-1:0];
    wgt_m[col][1] = w1[LANE_W-1:0];
    wgt_m[col][2] = w2[LANE_W-1:0];
    wgt_m[col][3] = w3[LANE_W-1:0];
    host_write(SEL_WGT, col, {w3[11:0], w2[11:0], w1[11:0], w0[11:0]});
  endtask

  task automatic load_random_weights();
    for (int c = 0; c < WGT_COLS; c++) begin
      write_weight_row(c, int'(lcg_next()), int'(lcg_next()), int'(lcg_next()),
                       int'(lcg_next()));
    end
    host_release();
  endtask

  task automatic make_random_rows(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      row_cnt[i] = int'(r % 9);  // 0 to 8 entries
      for (int e = 0; e < row_cnt[i]; e++) begin
        r = lcg_next();
        row_col[i][e] = r[COL_W-1:0];
        r = lcg_next();
        row_val[i][e] = r[LANE_W-1:0];
      end
    end
  endtask

  // rows go back to back from address 0 with each header ahead of its entries
  task automatic load_rows(input int n);
    int addr;
    addr = 0;
    for (int i = 0; i < n; i++) begin
      host_write(SEL_HDATA, addr, {29'h0, KIND_HDR, 6'(row_cnt[i]), 12'h000});
      addr++;
      for (int e = 0; e < row_cnt[i]; e++) begin
        host_write(SEL_HDATA, addr, {29'h0, KIND_ENT, row_col[i][e], row_val[i][e]});
        addr++;
      end
    end
    host_release();
  endtask

  task automatic run_layer(input int n);
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_cyc_q.delete();
    done_cnt = 0;
    @(posedge clk);
    #1;
    num_nodes_i = NODE_W'(n);
    start_i     = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    while (done_cnt == 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);  // room for a stray second done pulse
  endtask

  task automatic check_writes(input int n);
    logic [LANE_W-1:0] s;
    int                idx;
    check_true(wr_addr_q.size() == 4 * n,
               $sformatf("expected %0d feature writes but saw %0d", 4 * n, wr_addr_q.size()));
    if (wr_addr_q.size() == 4 * n) begin
      for (int r = 0; r < n; r++) begin
        for (int k = 0; k < NUM_LANES; k++) begin
          idx = r * NUM_LANES + k;
          s   = lane_sum(r, k);
          check_val($sformatf("feat_wr_o.addr[%0d]", idx), {16'h0, wr_addr_q[idx]}, 32'(idx));
          check_val($sformatf("feat_wr_o.data[%0d]", idx), wr_data_q[idx],
                    {{20{s[LANE_W-1]}}, s});
          if (k > 0) begin
            check_true(wr_cyc_q[idx] == wr_cyc_q[idx-1] + 1,
                       $sformatf("row %0d lane %0d was not written right after lane %0d",
                                 r, k, k - 1));
          end
        end
      end
    end
    check_true(done_cnt == 1, $sformatf("done_o pulsed %0d times instead of once", done_cnt));
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_val("feat_wr_o.ena", {31'h0, feat_wr.ena}, 32'h0);
    check_val("done_o", {31'h0, done_o}, 32'h0);
    check_val("debug_2_o", debug_2, 32'h0);
    check_val("debug_1_o", debug_1, BUILD_ID);
  endtask

  task automatic test_single_row();
    write_weight_row(5, 3, -2, 100, 7);
    write_weight_row(17, -1, 20, 2047, 0);
    write_weight_row(42, 50, -50, -3, 11);
    host_release();
    row_cnt[0]    = 3;
    row_col[0][0] = 6'd5;
    row_val[0][0] = 12'd10;
    row_col[0][1] = 6'd17;
    row_val[0][1] = 12'hff9;  // -7
    row_col[0][2] = 6'd42;
    row_val[0][2] = 12'd300;
    load_rows(1);
    run_layer(1);
    check_writes(1);
  endtask

  task automatic test_multi_rows();
    do_reset();
    make_random_rows(12);
    load_rows(12);
    run_layer(12);
    check_writes(12);
  endtask

  task automatic test_stage_flags(input int n);
    check_val("debug_2_o stage flags", {28'h0, debug_2[3:0]}, 32'hf);
    check_val("debug_2_o row count", {16'h0, debug_2[31:16]}, 32'(n));
  endtask

  task automatic test_captures();
    check_val("debug_3_o capture a", {20'h0, debug_3[11:0]}, {20'h0, lane_sum(TRIG_ROW_A, 2)});
    check_val("debug_3_o capture b", {20'h0, debug_3[27:16]}, {20'h0, lane_sum(TRIG_ROW_B, 2)});
    check_val("debug_3_o unused bits", {debug_3[31:28], 12'h0, debug_3[15:12], 12'h0}, 32'h0);
  endtask

  task automatic test_window_flag();
    do_reset();
    make_random_rows(10);  // last address is 39 and stays below the window
    load_rows(10);
    run_layer(10);
    check_writes(10);
    check_val("debug_2_o window flag", {31'h0, debug_2[4]}, 32'h0);
    do_reset();
    make_random_rows(11);
    load_rows(11);
    run_layer(11);
    check_writes(11);
    check_val("debug_2_o window flag", {31'h0, debug_2[4]}, 32'h1);
  endtask

  initial begin
    rst_n       = 1'b0;
    start_i     = 1'b0;
    num_nodes_i = '0;
    host_wr     = '0;
    lcg_state   = 32'd57431;

    do_reset();
    test_reset_state();
    load_random_weights();
    test_single_row();
    test_multi_rows();
    test_stage_flags(12);
    test_captures();
    test_window_flag();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/gnn_pkg.sv
hw/layer_ctrl.sv
spmm/h_data_bram.sv
spmm/spmm_engine.sv
hw/aggr_writer.sv
debug/debug_monitor.sv
hw/gnn_layer_top.sv
dv/tb_gnn_layer.sv

// ==== Makefile ====
# Verilator flow for the GNN layer slice

TOP := tb_gnn_layer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
